/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build cache_tb with Verilator, run it, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
		-f cache_sub.f --Mdir obj_dir
	./obj_dir/Vcache_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -q -x -F '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

/* cache_sub.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_data_ram.sv
hw/cache_tag_ram.sv
hw/cache_core_port.sv
hw/cache_ctrl.sv
hw/cache_mem_port.sv
hw/cache_top.sv
tb/cache_assertions.sv
tb/cache_tb.sv

/* hw/cache_cfg.svh */
// cache configuration: address, data, index and line offset widths

`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// word address width
`define CACHE_ADDR_W 16

// data word width in bits
`define CACHE_DATA_W 32

// 16 lines
`define CACHE_INDEX_W 4

// 4 words per line
`define CACHE_OFFSET_W 2

`define CACHE_LINE_WORDS (1 << `CACHE_OFFSET_W)

`endif

/* hw/cache_core_port.sv */
// cache core port, a four-phase slave that holds one command for the controller
`timescale 1ns/10ps

module cache_core_port (
    input  logic             clk,
    input  logic             rst_n,
    // core side
    input  logic             core_req,
    input  logic             core_we,
    input  cache_pkg::addr_t core_addr,
    input  cache_pkg::be_t   core_be,
    input  cache_pkg::data_t core_wdata,
    output logic             core_ack,
    output cache_pkg::data_t core_rdata,
    // controller side
    output logic             cmd_valid,
    output logic             cmd_we,
    output cache_pkg::addr_t cmd_addr,
    output cache_pkg::be_t   cmd_be,
    output cache_pkg::data_t cmd_wdata,
    input  logic             cmd_done,
    input  cache_pkg::data_t cmd_rdata
);

    typedef enum logic [1:0] {
        st_wait_req,
        st_busy,
        st_acked
    } state_t;

    state_t state_q;

    assign cmd_valid = (state_q == st_busy);
    assign core_ack  = (state_q == st_acked);

    // ------------------------------
    // handshake FSM
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_wait_req;
        end else begin
            case (state_q)
                // ack is low here so a high req is a new request
                st_wait_req: if (core_req) state_q <= st_busy;
                st_busy:     if (cmd_done) state_q <= st_acked;
                // hold ack until the core lets go
                st_acked:    if (!core_req) state_q <= st_wait_req;
                default:     state_q <= st_wait_req;
            endcase
        end
    end

    // request fields and result
    always_ff @(posedge clk) begin
        if (state_q == st_wait_req && core_req) begin
            cmd_we    <= core_we;
            cmd_addr  <= core_addr;
            cmd_be    <= core_be;
            cmd_wdata <= core_wdata;
        end
        if (state_q == st_busy && cmd_done) begin
            core_rdata <= cmd_rdata;
        end
    end

endmodule

/* hw/cache_ctrl.sv */
// cache controller for lookup, line fill and write-through
`timescale 1ns/10ps

`include "cache_cfg.svh"

module cache_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    // command from core port
    input  logic             cmd_valid,
    input  logic             cmd_we,
    input  cache_pkg::addr_t cmd_addr,
    input  cache_pkg::be_t   cmd_be,
    input  cache_pkg::data_t cmd_wdata,
    output logic             cmd_done,
    output cache_pkg::data_t cmd_rdata,
    // transfer to memory port
    output logic             xfer_start,
    output logic             xfer_we,
    output cache_pkg::addr_t xfer_addr,
    output cache_pkg::be_t   xfer_be,
    output cache_pkg::data_t xfer_wdata,
    input  logic             xfer_done,
    input  cache_pkg::data_t xfer_rdata
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_compare,
        st_fill,
        st_fill_wait,
        st_write_through,
        st_answer
    } state_t;

    state_t    state_q;
    tag_t      cmd_tag;
    index_t    cmd_index;
    offset_t   cmd_offset;
    offset_t   fill_cnt_q;
    ram_addr_t core_ram_addr;
    ram_addr_t fill_ram_addr;
    tag_t      rd_tag;
    logic      rd_valid;
    data_t     ram_rdata;
    data_t     rdata_q;
    logic      hit;
    logic      hit_q;
    logic      fill_last;
    logic      tag_wr_en;
    logic      ram_core_write;
    logic      ram_fill_write;

    assign {cmd_tag, cmd_index, cmd_offset} = cmd_addr;
    assign core_ram_addr = {cmd_index, cmd_offset};
    assign fill_ram_addr = {cmd_index, fill_cnt_q};

    // RAM outputs belong to the read issued in the previous cycle
    assign hit       = rd_valid && (rd_tag == cmd_tag);
    assign fill_last = (fill_cnt_q == offset_t'(`CACHE_LINE_WORDS - 1));

    assign ram_fill_write = (state_q == st_fill_wait) && xfer_done;
    // tag goes valid together with the last word of the line
    assign tag_wr_en      = ram_fill_write && fill_last;
    assign ram_core_write = (state_q == st_write_through) && xfer_done && hit_q;

    // ------------------------------
    // memory transfer request
    // ------------------------------

    assign xfer_start = (state_q == st_fill) || ((state_q == st_compare) && cmd_we);
    assign xfer_we    = cmd_we;
    assign xfer_addr  = (state_q == st_fill) ? {cmd_tag, cmd_index, fill_cnt_q} : cmd_addr;
    assign xfer_be    = (state_q == st_fill) ? '1 : cmd_be;
    assign xfer_wdata = cmd_wdata;

    assign cmd_done  = (state_q == st_answer);
    assign cmd_rdata = rdata_q;

    // ------------------------------
    // control FSM
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            fill_cnt_q <= '0;
            hit_q      <= 1'b0;
        end else begin
            case (state_q)
                // RAMs are read from cmd_addr in this cycle
                st_idle: begin
                    if (cmd_valid) state_q <= st_compare;
                end
                // re-read after the line fill
                st_lookup: state_q <= st_compare;
                st_compare: begin
                    hit_q <= hit;
                    if (cmd_we) begin
                        state_q <= st_write_through;
                    end else if (hit) begin
                        state_q <= st_answer;
                    end else begin
                        fill_cnt_q <= '0;
                        state_q    <= st_fill;
                    end
                end
                st_fill: state_q <= st_fill_wait;
                st_fill_wait: begin
                    if (xfer_done) begin
                        if (fill_last) begin
                            state_q <= st_lookup;
                        end else begin
                            fill_cnt_q <= fill_cnt_q + 1'b1;
                            state_q    <= st_fill;
                        end
                    end
                end
                // memory first, cached bytes after
                st_write_through: begin
                    if (xfer_done) state_q <= st_answer;
                end
                st_answer: state_q <= st_idle;
                default:   state_q <= st_idle;
            endcase
        end
    end

    // read result register
    always_ff @(posedge clk) begin
        if (state_q == st_compare && !cmd_we && hit) begin
            rdata_q <= ram_rdata;
        end
    end

    cache_tag_ram tag_ram_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_index (cmd_index),
        .rd_tag   (rd_tag),
        .rd_valid (rd_valid),
        .wr_en    (tag_wr_en),
        .wr_index (cmd_index),
        .wr_tag   (cmd_tag)
    );

    cache_data_ram #(
        .aw ($bits(ram_addr_t)),
        .dw ($bits(data_t))
    ) data_ram_i (
        .clk              (clk),
        .core_write       (ram_core_write),
        .core_address     (core_ram_addr),
        .core_byte_enable (cmd_be),
        .core_writedata   (cmd_wdata),
        .core_readdata    (ram_rdata),
        .fill_write       (ram_fill_write),
        .fill_address     (fill_ram_addr),
        .fill_byte_enable ('1),
        .fill_writedata   (xfer_rdata)
    );

endmodule

/* hw/cache_data_ram.sv */
// cache data RAM with two byte-enabled write ports and one registered read port
`timescale 1ns/10ps

`include "cache_cfg.svh"

module cache_data_ram #(
    parameter int aw = `CACHE_INDEX_W + `CACHE_OFFSET_W,
    parameter int dw = `CACHE_DATA_W
) (
    input  logic              clk,
    // core side, also the read port
    input  logic              core_write,
    input  logic [aw-1:0]     core_address,
    input  logic [dw/8-1:0]   core_byte_enable,
    input  logic [dw-1:0]     core_writedata,
    output logic [dw-1:0]     core_readdata,
    // line fill side
    input  logic              fill_write,
    input  logic [aw-1:0]     fill_address,
    input  logic [dw/8-1:0]   fill_byte_enable,
    input  logic [dw-1:0]     fill_writedata
);

    localparam int num_bytes = dw / 8;

    logic [dw-1:0] mem [0:(1<<aw)-1];

    always_ff @(posedge clk) begin
        // core port byte writes
        if (core_write) begin
            for (int i = 0; i < num_bytes; i++) begin
                if (core_byte_enable[i]) begin
                    mem[core_address][i*8 +: 8] <= core_writedata[i*8 +: 8];
                end
            end
        end
        // fill port, last assignment wins on a collision
        if (fill_write) begin
            for (int j = 0; j < num_bytes; j++) begin
                if (fill_byte_enable[j]) begin
                    mem[fill_address][j*8 +: 8] <= fill_writedata[j*8 +: 8];
                end
            end
        end
        // one cycle read latency
        core_readdata <= mem[core_address];
    end

endmodule

/* hw/cache_mem_port.sv */
// cache memory port, a four-phase master that runs one transfer at a time
`timescale 1ns/10ps

module cache_mem_port (
    input  logic             clk,
    input  logic             rst_n,
    // transfer from controller
    input  logic             xfer_start,
    input  logic             xfer_we,
    input  cache_pkg::addr_t xfer_addr,
    input  cache_pkg::be_t   xfer_be,
    input  cache_pkg::data_t xfer_wdata,
    output logic             xfer_done,
    output cache_pkg::data_t xfer_rdata,
    // memory side
    output logic             mem_req,
    output logic             mem_we,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::be_t   mem_be,
    output cache_pkg::data_t mem_wdata,
    input  logic             mem_ack,
    input  cache_pkg::data_t mem_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release
    } state_t;

    state_t state_q;
    // next transfer arrived while ack was still high
    logic   pend_q;

    assign mem_req = (state_q == st_req);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            pend_q    <= 1'b0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            case (state_q)
                st_idle: if (xfer_start) state_q <= st_req;
                st_req: begin
                    if (mem_ack) begin
                        xfer_done <= 1'b1;
                        state_q   <= st_release;
                    end
                end
                st_release: begin
                    if (xfer_start) pend_q <= 1'b1;
                    if (!mem_ack) begin
                        if (pend_q || xfer_start) begin
                            pend_q  <= 1'b0;
                            state_q <= st_req;
                        end else begin
                            state_q <= st_idle;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // fields stay put while mem_req is high
    always_ff @(posedge clk) begin
        if (xfer_start) begin
            mem_we    <= xfer_we;
            mem_addr  <= xfer_addr;
            mem_be    <= xfer_be;
            mem_wdata <= xfer_wdata;
        end
        if (state_q == st_req && mem_ack) begin
            xfer_rdata <= mem_rdata;
        end
    end

endmodule

/* hw/cache_pkg.sv */
// cache shared types for core and memory transfers and RAM addressing

`include "cache_cfg.svh"

package cache_pkg;

    // ------------------------------
    // transfer fields
    // ------------------------------

    typedef logic [`CACHE_ADDR_W-1:0] addr_t;

    typedef logic [`CACHE_DATA_W-1:0] data_t;

    // one enable per byte lane
    typedef logic [`CACHE_DATA_W/8-1:0] be_t;

    // ------------------------------
    // address split
    // ------------------------------

    // tag sits above index and offset
    typedef logic [`CACHE_ADDR_W-`CACHE_INDEX_W-`CACHE_OFFSET_W-1:0] tag_t;

    typedef logic [`CACHE_INDEX_W-1:0] index_t;

    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    // data RAM word address {index, offset}
    typedef logic [`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] ram_addr_t;

endpackage

/* hw/cache_tag_ram.sv */
// cache tag array with per-line valid bits and a registered read
`timescale 1ns/10ps

module cache_tag_ram (
    input  logic              clk,
    input  logic              rst_n,
    input  cache_pkg::index_t rd_index,
    output cache_pkg::tag_t   rd_tag,
    output logic              rd_valid,
    input  logic              wr_en,
    input  cache_pkg::index_t wr_index,
    input  cache_pkg::tag_t   wr_tag
);

    import cache_pkg::*;

    localparam int lines = 1 << $bits(index_t);

    tag_t       tag_mem [0:lines-1];
    logic [lines-1:0] valid_q;

    // tag storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
        rd_tag <= tag_mem[rd_index];
    end

    // ------------------------------
    // valid bits
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_index] <= 1'b1;
            end
            // registered alongside the tag
            rd_valid <= valid_q[rd_index];
        end
    end

endmodule

/* hw/cache_top.sv */
// cache top level joining core port, controller and memory port
`timescale 1ns/10ps

module cache_top (
    input  logic             clk,
    input  logic             rst_n,
    // core interface
    input  logic             core_req,
    input  logic             core_we,
    input  cache_pkg::addr_t core_addr,
    input  cache_pkg::be_t   core_be,
    input  cache_pkg::data_t core_wdata,
    output logic             core_ack,
    output cache_pkg::data_t core_rdata,
    // memory interface
    output logic             mem_req,
    output logic             mem_we,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::be_t   mem_be,
    output cache_pkg::data_t mem_wdata,
    input  logic             mem_ack,
    input  cache_pkg::data_t mem_rdata
);

    import cache_pkg::*;

    // ------------------------------
    // command and transfer wires
    // ------------------------------

    logic  cmd_valid;
    logic  cmd_we;
    addr_t cmd_addr;
    be_t   cmd_be;
    data_t cmd_wdata;
    logic  cmd_done;
    data_t cmd_rdata;

    logic  xfer_start;
    logic  xfer_we;
    addr_t xfer_addr;
    be_t   xfer_be;
    data_t xfer_wdata;
    logic  xfer_done;
    data_t xfer_rdata;

    cache_core_port core_port_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req   (core_req),
        .core_we    (core_we),
        .core_addr  (core_addr),
        .core_be    (core_be),
        .core_wdata (core_wdata),
        .core_ack   (core_ack),
        .core_rdata (core_rdata),
        .cmd_valid  (cmd_valid),
        .cmd_we     (cmd_we),
        .cmd_addr   (cmd_addr),
        .cmd_be     (cmd_be),
        .cmd_wdata  (cmd_wdata),
        .cmd_done   (cmd_done),
        .cmd_rdata  (cmd_rdata)
    );

    cache_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_we     (cmd_we),
        .cmd_addr   (cmd_addr),
        .cmd_be     (cmd_be),
        .cmd_wdata  (cmd_wdata),
        .cmd_done   (cmd_done),
        .cmd_rdata  (cmd_rdata),
        .xfer_start (xfer_start),
        .xfer_we    (xfer_we),
        .xfer_addr  (xfer_addr),
        .xfer_be    (xfer_be),
        .xfer_wdata (xfer_wdata),
        .xfer_done  (xfer_done),
        .xfer_rdata (xfer_rdata)
    );

    cache_mem_port mem_port_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .xfer_start (xfer_start),
        .xfer_we    (xfer_we),
        .xfer_addr  (xfer_addr),
        .xfer_be    (xfer_be),
        .xfer_wdata (xfer_wdata),
        .xfer_done  (xfer_done),
        .xfer_rdata (xfer_rdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_be     (mem_be),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

endmodule

/* tb/cache_assertions.sv */
// cache handshake checks on the top-level core and memory ports
`timescale 1ns/10ps

module cache_assertions (
    input logic             clk,
    input logic             rst_n,
    input logic             core_req,
    input logic             core_ack,
    input logic             mem_req,
    input logic             mem_we,
    input cache_pkg::addr_t mem_addr,
    input cache_pkg::be_t   mem_be,
    input cache_pkg::data_t mem_wdata,
    input logic             mem_ack
);

    // ------------------------------
    // memory side, cache is master
    // ------------------------------

    mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else $error("mem_req dropped before mem_ack arrived");

    // fields only load while mem_req is low
    mem_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && $past(mem_req) |-> $stable({mem_we, mem_addr, mem_be, mem_wdata}))
        else $error("memory request fields changed while mem_req was high");

    // ------------------------------
    // core side, cache is slave
    // ------------------------------

    ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(core_ack) |-> $past(core_req))
        else $error("core_ack rose without core_req");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(core_ack) |-> !$past(core_req))
        else $error("core_ack fell while core_req was still high");

endmodule

bind cache_top cache_assertions assertions_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .core_req  (core_req),
    .core_ack  (core_ack),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_be    (mem_be),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack)
);

/* tb/cache_tb.sv */
// cache testbench with memory model, reference model and random traffic
`timescale 1ns/10ps

`include "cache_cfg.svh"

module cache_tb;

    import cache_pkg::*;

    localparam int line_words   = `CACHE_LINE_WORDS;
    localparam int lines        = 1 << `CACHE_INDEX_W;
    localparam int mem_size     = 1 << `CACHE_ADDR_W;
    localparam int reset_cycles = 10;
    localparam int random_ops   = 300;
    // sweep, revisit, write and read pairs, eviction, random
    localparam int total_ops    = lines + lines * line_words + 4 * lines + 8 + random_ops;
    localparam int timeout_cycles = total_ops * 80 + reset_cycles;

    logic  clk;
    logic  rst_n;
    logic  core_req;
    logic  core_we;
    addr_t core_addr;
    be_t   core_be;
    data_t core_wdata;
    logic  core_ack;
    data_t core_rdata;
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    be_t   mem_be;
    data_t mem_wdata;
    logic  mem_ack;
    data_t mem_rdata;

    data_t mem_words    [0:mem_size-1];
    data_t shadow_mem   [0:mem_size-1];
    tag_t  shadow_tag   [0:lines-1];
    logic  shadow_valid [0:lines-1];

    // memory traffic of the current operation
    addr_t rd_log[$];
    addr_t wr_addr_log[$];
    be_t   wr_be_log[$];
    data_t wr_data_log[$];

    logic        op_is_read;
    addr_t       cur_addr;
    data_t       exp_rdata;
    logic        ack_prev;
    logic [31:0] stim_state;
    logic [31:0] delay_state;
    int          cycle_cnt;
    logic        fail_reported = 1'b0;
    logic        pass_reached = 1'b0;

    cache_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req   (core_req),
        .core_we    (core_we),
        .core_addr  (core_addr),
        .core_be    (core_be),
        .core_wdata (core_wdata),
        .core_ack   (core_ack),
        .core_rdata (core_rdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_be     (mem_be),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    always #10 clk = ~clk;

    // ------------------------------
    // helpers and reference model
    // ------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = lcg_next(stim_state);
        return stim_state;
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t w;
        w = old_word;
        for (int b = 0; b < $bits(be_t); b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return w;
    endfunction

    // memory contents as the core should see them
    function automatic data_t ref_read(input addr_t a);
        return shadow_mem[a];
    endfunction

    task automatic report_error(input string msg);
        $display("** Error @%0t: %s", $time, msg);
        fail_reported = 1'b1;
        $display("** FAIL **");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_data(input addr_t a, input data_t got, input data_t exp);
        if (got !== exp) begin
            report_error($sformatf("read %h returned %h, expected %h", a, got, exp));
        end
    endtask

    task automatic check_fills(input addr_t base, input int exp_reads);
        if (rd_log.size() != exp_reads) begin
            report_error($sformatf("%0d memory reads, expected %0d", rd_log.size(), exp_reads));
        end
        // line fill walks the offsets in order
        for (int w = 0; w < exp_reads; w++) begin
            if (rd_log[w] !== base + addr_t'(w)) begin
                report_error($sformatf("fill read %0d at %h, expected %h",
                                       w, rd_log[w], base + addr_t'(w)));
            end
        end
    endtask

    task automatic check_write(input logic exp_write, input addr_t a, input be_t be,
                               input data_t d);
        int exp_n;
        exp_n = exp_write ? 1 : 0;
        if (wr_addr_log.size() != exp_n) begin
            report_error($sformatf("%0d memory writes, expected %0d",
                                   wr_addr_log.size(), exp_n));
        end
        if (exp_write) begin
            if (wr_addr_log[0] !== a || wr_be_log[0] !== be || wr_data_log[0] !== d) begin
                report_error($sformatf("memory write %h/%h/%h, expected %h/%h/%h",
                                       wr_addr_log[0], wr_be_log[0], wr_data_log[0],
                                       a, be, d));
            end
        end
    endtask

    // one four-phase core transaction plus traffic checks
    task automatic do_op(input logic we, input addr_t addr, input be_t be, input data_t wdata);
        tag_t    t;
        index_t  idx;
        offset_t off;
        logic    hit;
        addr_t   base;
        {t, idx, off} = addr;
        hit  = shadow_valid[idx] && (shadow_tag[idx] == t);
        base = {t, idx, offset_t'(0)};
        rd_log.delete();
        wr_addr_log.delete();
        wr_be_log.delete();
        wr_data_log.delete();
        op_is_read = !we;
        cur_addr   = addr;
        if (!we) begin
            exp_rdata = ref_read(addr);
        end
        core_we    = we;
        core_addr  = addr;
        core_be    = be;
        core_wdata = wdata;
        core_req   = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!core_ack);
        core_req = 1'b0;
        while (core_ack) begin
            @(posedge clk);
            #1;
        end
        if (we) begin
            // write-through without allocate
            shadow_mem[addr] = merge_bytes(shadow_mem[addr], wdata, be);
            check_fills(base, 0);
            check_write(1'b1, addr, be, wdata);
        end else begin
            check_fills(base, hit ? 0 : line_words);
            check_write(1'b0, addr, be, wdata);
            shadow_tag[idx]   = t;
            shadow_valid[idx] = 1'b1;
        end
    endtask

    // ------------------------------
    // memory model
    // ------------------------------

    task automatic serve_mem();
        logic        we;
        addr_t       a;
        be_t         be;
        data_t       wd;
        int unsigned delay;
        we = mem_we;
        a  = mem_addr;
        be = mem_be;
        wd = mem_wdata;
        delay_state = lcg_next(delay_state);
        delay = (delay_state >> 16) % 32'd5;
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        if (we) begin
            mem_words[a] = merge_bytes(mem_words[a], wd, be);
            wr_addr_log.push_back(a);
            wr_be_log.push_back(be);
            wr_data_log.push_back(wd);
        end else begin
            mem_rdata = mem_words[a];
            rd_log.push_back(a);
        end
        mem_ack = 1'b1;
        while (mem_req) begin
            @(posedge clk);
            #1;
        end
        mem_ack = 1'b0;
    endtask

    initial begin
        logic [31:0] s;
        mem_ack     = 1'b0;
        mem_rdata   = '0;
        delay_state = 32'h6b9f_619e;
        s = 32'h6b9f_619e;
        for (int a = 0; a < mem_size; a++) begin
            s = lcg_next(s);
            mem_words[addr_t'(a)] = s ^ 32'(a);
        end
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && mem_req) begin
                serve_mem();
            end
        end
    end

    // read results checked when core_ack rises
    initial begin
        ack_prev = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (core_ack && !ack_prev && op_is_read) begin
                check_data(cur_addr, core_rdata, exp_rdata);
            end
            ack_prev = core_ack;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the cache did not finish within %0d cycles", timeout_cycles);
        fail_reported = 1'b1;
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    final begin
        if (!pass_reached && !fail_reported) begin
            $display("** FAIL **");
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin
        logic [31:0] s;
        logic [31:0] r;
        addr_t       a_addr;
        addr_t       b_addr;
        logic        we;
        be_t         be;
        data_t       wd;
        clk        = 1'b0;
        rst_n      = 1'b0;
        core_req   = 1'b0;
        core_we    = 1'b0;
        core_addr  = '0;
        core_be    = '0;
        core_wdata = '0;
        op_is_read = 1'b0;
        cur_addr   = '0;
        exp_rdata  = '0;
        // same pattern as the memory model
        s = 32'h6b9f_619e;
        for (int a = 0; a < mem_size; a++) begin
            s = lcg_next(s);
            shadow_mem[addr_t'(a)] = s ^ 32'(a);
        end
        stim_state = s;
        for (int i = 0; i < lines; i++) begin
            shadow_tag[i]   = '0;
            shadow_valid[i] = 1'b0;
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // one cold miss per line
        for (int i = 0; i < lines; i++) begin
            do_op(1'b0, {tag_t'(0), index_t'(i), offset_t'(i)}, '0, '0);
        end
        // every word of the filled lines
        for (int i = 0; i < lines; i++) begin
            for (int w = 0; w < line_words; w++) begin
                do_op(1'b0, {tag_t'(0), index_t'(i), offset_t'(w)}, '0, '0);
            end
        end
        // write hit and write miss with a read back after each
        for (int i = 0; i < lines; i++) begin
            r  = next_rand();
            be = be_t'(r[27:24]);
            wd = next_rand();
            do_op(1'b1, {tag_t'(0), index_t'(i), offset_t'(i + 1)}, be, wd);
            do_op(1'b0, {tag_t'(0), index_t'(i), offset_t'(i + 1)}, '0, '0);
            do_op(1'b1, {tag_t'(1), index_t'(i), offset_t'(i)}, ~be, ~wd);
            do_op(1'b0, {tag_t'(1), index_t'(i), offset_t'(i)}, '0, '0);
        end

        // ------------------------------
        // eviction on one index
        // ------------------------------
        // b sits at the same word of the line as a
        a_addr = {tag_t'(8), index_t'(5), offset_t'(1)};
        b_addr = {tag_t'(9), index_t'(5), offset_t'(1)};
        for (int k = 0; k < 3; k++) begin
            do_op(1'b0, a_addr, '0, '0);
            do_op(1'b0, b_addr, '0, '0);
        end
        // write miss to a leaves b resident
        do_op(1'b1, a_addr, '1, next_rand());
        do_op(1'b0, b_addr, '0, '0);

        // random traffic over four tags
        for (int n = 0; n < random_ops; n++) begin
            r  = next_rand();
            we = r[31];
            be = be_t'(r[17:14]);
            wd = next_rand();
            do_op(we, {tag_t'(r[25:24]), index_t'(r[23:20]), offset_t'(r[19:18])}, be, wd);
        end

        pass_reached = 1'b1;
        $display("** PASS **");
        $finish;
    end

endmodule
